//--- img_pkg.sv
//********************
// stored image geometry and buffer word layouts
// one 12 bit word per pixel, read as rgb444 or as y plus chroma nibble
// the image is fixed at 80 x 60, the buffer address is 13 bits
//********************
`default_nettype none

package img_pkg;

  localparam int unsigned img_cols    = 80;
  localparam int unsigned img_rows    = 60;
  localparam int unsigned img_pxls    = img_cols * img_rows;  // 4800
  localparam int unsigned nb_img_pxls = 13;                   // 2^13 covers 4800
  localparam int unsigned nb_buf      = 12;                   // buffer word width

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;

  typedef struct packed {
    logic [7:0] y;  // full luma byte
    logic [3:0] c;  // top nibble of the chroma byte
  } yc_t;

  // same stored word, decoded by display mode
  typedef union packed {
    rgb444_t rgb;
    yc_t     yc;
  } buf_pixel_t;

  typedef struct packed {
    logic                   we;
    logic [nb_img_pxls-1:0] addr;
    buf_pixel_t             data;
  } cap_wr_t;

endpackage

`default_nettype wire

//--- vga_pkg.sv
//********************
// 640 x 480 @ 60 Hz timing, 25 MHz pixel rate from a 50 MHz clk
// both syncs are active low
//********************
`default_nettype none

package vga_pkg;

  localparam int unsigned h_visible = 640;
  localparam int unsigned h_front   = 16;
  localparam int unsigned h_sync    = 96;
  localparam int unsigned h_back    = 48;
  localparam int unsigned h_total   = h_visible + h_front + h_sync + h_back;  // 800

  localparam int unsigned v_visible = 480;
  localparam int unsigned v_front   = 10;
  localparam int unsigned v_sync    = 2;
  localparam int unsigned v_back    = 33;
  localparam int unsigned v_total   = v_visible + v_front + v_sync + v_back;  // 525

  typedef enum logic [1:0] {
    mode_rgb      = 2'd0,  // camera rgb565
    mode_yuv      = 2'd1,  // camera yuv, shown as gray
    mode_rgb_test = 2'd2,  // colour bars
    mode_yuv_test = 2'd3   // gray ramp
  } disp_mode_t;

  typedef struct packed {
    logic [9:0] col;
    logic [9:0] row;
    logic       visible;
    logic       new_pxl;  // pixel strobe, every second clk
    logic       hsync;    // raw level, active low
    logic       vsync;
  } scan_pos_t;

endpackage

`default_nettype wire

//--- video_ctrl.sv
//********************
// sw2 must be a clean level, no debounce here
// camera reset is held low 64 clk after rst, xclk is clk / 2
// capture is frozen in both test modes
//********************
`default_nettype none

module video_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                sw2,
  input  logic                frame_done,
  output vga_pkg::disp_mode_t disp_mode,
  output logic                capture_en,
  output logic                ov7670_rst_n,
  output logic                ov7670_xclk,
  output logic [7:0]          led
);
  import vga_pkg::*;

  logic [2:0] sw2_s;       // 2 sync flops plus previous value
  logic       sw2_rise;
  logic [5:0] cnt_rst;     // camera reset hold
  logic       frame_seen;
  logic [3:0] cnt_frm;

  assign sw2_rise = sw2_s[1] & ~sw2_s[2];

  always_ff @(posedge clk) begin
    if (rst) begin
      sw2_s        <= '0;
      disp_mode    <= mode_rgb;
      cnt_rst      <= '0;
      ov7670_rst_n <= 1'b0;
      ov7670_xclk  <= 1'b0;
      frame_seen   <= 1'b0;
      cnt_frm      <= '0;
    end else begin
      sw2_s       <= {sw2_s[1:0], sw2};
      ov7670_xclk <= ~ov7670_xclk;  // 25 MHz to the camera
      if (sw2_rise)
        disp_mode <= disp_mode_t'(disp_mode + 2'd1);  // wraps 3 -> 0
      // release the camera after 64 clk
      if (!ov7670_rst_n) begin
        cnt_rst <= cnt_rst + 6'd1;
        if (cnt_rst == 6'd63)
          ov7670_rst_n <= 1'b1;
      end
      if (frame_done) begin
        frame_seen <= 1'b1;
        cnt_frm    <= cnt_frm + 4'd1;  // wraps
      end
    end
  end

  assign capture_en = (disp_mode == mode_rgb) || (disp_mode == mode_yuv);

  assign led = {frame_seen, 1'b0, disp_mode, cnt_frm};

  // mode steps only after sw2 rose at the pin, 3 flops back
  a_mode_step : assert property (@(posedge clk) disable iff (rst)
    !$stable(disp_mode) |-> $past(sw2, 3) && (!$past(sw2, 4) || $past(rst, 4)));

endmodule

`default_nettype wire

//--- ov7670_capture.sv
//********************
// pclk, vsync, href and d are sampled in the clk domain through 2 flops
// pclk must stay below about clk / 4
// write comes 3 to 4 clk after the second pclk edge of a pair
// pixels past img_pxls in one frame are dropped
//********************
`default_nettype none

module ov7670_capture (
  input  logic                clk,
  input  logic                rst,
  input  logic                pclk,
  input  logic                vsync,
  input  logic                href,
  input  logic [7:0]          d,
  input  vga_pkg::disp_mode_t disp_mode,
  input  logic                capture_en,
  output img_pkg::cap_wr_t    cap_wr,
  output logic                frame_done
);
  import img_pkg::*;
  import vga_pkg::*;

  logic [2:0]             pclk_s;   // [2] is the previous synced value
  logic [2:0]             vsync_s;
  logic [1:0]             href_s;
  logic [7:0]             d_s1, d_s2;
  logic                   pclk_rise, vsync_fall;
  logic                   phase;    // 1 once the first byte is held
  logic [7:0]             b1;
  logic [nb_img_pxls-1:0] addr;
  logic                   wrote;    // a write happened this frame
  buf_pixel_t             pix_nxt;

  always_ff @(posedge clk) begin
    d_s1 <= d;  // data rides alongside pclk, no reset
    d_s2 <= d_s1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pclk_s  <= '0;
      vsync_s <= '0;
      href_s  <= '0;
    end else begin
      pclk_s  <= {pclk_s[1:0], pclk};
      vsync_s <= {vsync_s[1:0], vsync};
      href_s  <= {href_s[0], href};
    end
  end

  assign pclk_rise  = pclk_s[1] & ~pclk_s[2];
  assign vsync_fall = vsync_s[2] & ~vsync_s[1];

  // pack the byte pair
  always_comb begin
    if (disp_mode inside {mode_yuv, mode_yuv_test}) begin
      pix_nxt.yc.y = d_s2;       // chroma came first, Y second
      pix_nxt.yc.c = b1[7:4];
    end else begin
      pix_nxt.rgb.red   = b1[7:4];                // rgb565 top bits
      pix_nxt.rgb.green = {b1[2:0], d_s2[7]};
      pix_nxt.rgb.blue  = d_s2[4:1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= 1'b0;
      addr       <= '0;
      wrote      <= 1'b0;
      frame_done <= 1'b0;
      cap_wr.we  <= 1'b0;
    end else begin
      cap_wr.we  <= 1'b0;
      frame_done <= 1'b0;
      if (vsync_s[1]) begin  // frame blanking restarts the image
        phase <= 1'b0;
        addr  <= '0;
      end else if (pclk_rise && href_s[1]) begin
        if (!phase) begin
          b1    <= d_s2;
          phase <= 1'b1;
        end else begin
          phase       <= 1'b0;
          cap_wr.addr <= addr;
          cap_wr.data <= pix_nxt;
          if (addr < img_pxls) begin
            addr      <= addr + 1'b1;
            cap_wr.we <= capture_en;  // frozen buffer in test modes
            wrote     <= wrote | capture_en;
          end
        end
      end
      if (vsync_fall && wrote) begin
        frame_done <= 1'b1;
        wrote      <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- frame_buffer.sv
//********************
// 4800 x 12 simple dual-port RAM, read data 1 clk after the address
// same-address read and write return the old word
//********************
`default_nettype none

module frame_buffer (
  input  logic                            clk,
  input  img_pkg::cap_wr_t                cap_wr,
  input  logic [img_pkg::nb_img_pxls-1:0] frame_addr,
  output img_pkg::buf_pixel_t             frame_pixel
);
  import img_pkg::*;

  logic [nb_buf-1:0] mem [0:img_pxls-1];  // block ram, no init

  always_ff @(posedge clk) begin
    if (cap_wr.we)
      mem[cap_wr.addr] <= cap_wr.data;
    frame_pixel <= mem[frame_addr];  // read before write
  end

  // a write must land inside the stored image
  a_wr_range : assert property (@(posedge clk)
    cap_wr.we |-> (cap_wr.addr < img_pxls));

endmodule

`default_nettype wire

//--- vga_sync.sv
//********************
// 640 x 480 scan counters, one pixel every second clk
// sync levels are raw and combinational, vga_display registers them
//********************
`default_nettype none

module vga_sync (
  input  logic               clk,
  input  logic               rst,
  output vga_pkg::scan_pos_t scan
);
  import vga_pkg::*;

  localparam int unsigned hs_start = h_visible + h_front;  // 656
  localparam int unsigned hs_end   = hs_start + h_sync;    // 752, exclusive
  localparam int unsigned vs_start = v_visible + v_front;  // 490
  localparam int unsigned vs_end   = vs_start + v_sync;    // 492, exclusive

  logic       pxl_tgl;
  logic [9:0] col;
  logic [9:0] row;

  always_ff @(posedge clk) begin
    if (rst) begin
      pxl_tgl <= 1'b0;
      col     <= '0;
      row     <= '0;
    end else begin
      pxl_tgl <= ~pxl_tgl;
      if (pxl_tgl) begin  // advance on the pixel strobe
        if (col == 10'(h_total - 1)) begin
          col <= '0;
          if (row == 10'(v_total - 1))
            row <= '0;
          else
            row <= row + 10'd1;
        end else begin
          col <= col + 10'd1;
        end
      end
    end
  end

  always_comb begin
    scan.col     = col;
    scan.row     = row;
    scan.new_pxl = pxl_tgl;
    scan.visible = (col < h_visible) && (row < v_visible);
    scan.hsync   = !((col >= hs_start) && (col < hs_end));  // active low
    scan.vsync   = !((row >= vs_start) && (row < vs_end));
  end

  a_col_range : assert property (@(posedge clk) disable iff (rst) col < h_total);
  a_row_range : assert property (@(posedge clk) disable iff (rst) row < v_total);

endmodule

`default_nettype wire

//--- vga_display.sv
//********************
// 2 clk from scan to colours and syncs, both delayed alike
// the stored image shows in the top-left 80 x 60 corner
// test patterns fill the whole visible area
//********************
`default_nettype none

module vga_display (
  input  logic                            clk,
  input  logic                            rst,
  input  vga_pkg::scan_pos_t              scan,
  input  vga_pkg::disp_mode_t             disp_mode,
  input  img_pkg::buf_pixel_t             frame_pixel,
  output logic [img_pkg::nb_img_pxls-1:0] frame_addr,
  output logic [3:0]                      vga_red,
  output logic [3:0]                      vga_green,
  output logic [3:0]                      vga_blue,
  output logic                            vga_hsync,
  output logic                            vga_vsync
);
  import img_pkg::*;
  import vga_pkg::*;

  logic       in_win;
  logic       s1_visible, s1_in_win, s1_hsync, s1_vsync;
  logic [3:0] s1_col_hi;  // col[7:4]
  logic [3:0] s1_row_hi;  // row[5:2]
  logic [3:0] red_nxt, green_nxt, blue_nxt;

  assign in_win = (scan.col < img_cols) && (scan.row < img_rows);

  // stage 1 address, the RAM answers next clk
  always_comb begin
    if (in_win)
      frame_addr = nb_img_pxls'(scan.row) * nb_img_pxls'(img_cols) + nb_img_pxls'(scan.col);
    else
      frame_addr = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_visible <= 1'b0;
      s1_in_win  <= 1'b0;
      s1_hsync   <= 1'b1;
      s1_vsync   <= 1'b1;
    end else begin
      s1_visible <= scan.visible;
      s1_in_win  <= in_win;
      s1_hsync   <= scan.hsync;
      s1_vsync   <= scan.vsync;
    end
  end

  always_ff @(posedge clk) begin
    s1_col_hi <= scan.col[7:4];  // pattern bits only
    s1_row_hi <= scan.row[5:2];
  end

  // stage 2 decode of the buffer word
  always_comb begin
    red_nxt   = '0;
    green_nxt = '0;
    blue_nxt  = '0;
    if (s1_visible) begin
      unique case (disp_mode)
        mode_rgb: if (s1_in_win) begin
          red_nxt   = frame_pixel.rgb.red;
          green_nxt = frame_pixel.rgb.green;
          blue_nxt  = frame_pixel.rgb.blue;
        end
        mode_yuv: if (s1_in_win) begin
          red_nxt   = frame_pixel.yc.y[7:4];  // luma only, gray
          green_nxt = frame_pixel.yc.y[7:4];
          blue_nxt  = frame_pixel.yc.y[7:4];
        end
        mode_rgb_test: begin
          red_nxt   = {s1_col_hi[2:0], s1_col_hi[2]};  // col[6:4], msb repeated
          green_nxt = s1_row_hi;
        end
        mode_yuv_test: begin
          red_nxt   = s1_col_hi;  // gray ramp
          green_nxt = s1_col_hi;
          blue_nxt  = s1_col_hi;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_red   <= '0;
      vga_green <= '0;
      vga_blue  <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      vga_red   <= red_nxt;
      vga_green <= green_nxt;
      vga_blue  <= blue_nxt;
      vga_hsync <= s1_hsync;  // aligned with the colours
      vga_vsync <= s1_vsync;
    end
  end

endmodule

`default_nettype wire

//--- top_ov7670.sv
//********************
// one 50 MHz clk domain, no PLL and no SCCB setup
// sioc held high, siod released
//********************
`default_nettype none

module top_ov7670 (
  input  logic       clk,
  input  logic       rst,
  input  logic       sw2,
  input  logic       ov7670_pclk,
  input  logic       ov7670_vsync,
  input  logic       ov7670_href,
  input  logic [7:0] ov7670_d,
  output logic       ov7670_xclk,
  output logic       ov7670_rst_n,
  output logic       ov7670_sioc,
  output wire        ov7670_siod,
  output logic [7:0] led,
  output logic [3:0] vga_red,
  output logic [3:0] vga_green,
  output logic [3:0] vga_blue,
  output logic       vga_hsync,
  output logic       vga_vsync
);
  import img_pkg::*;
  import vga_pkg::*;

  disp_mode_t             disp_mode;
  logic                   capture_en;
  logic                   frame_done;
  cap_wr_t                cap_wr;
  scan_pos_t              scan;
  logic [nb_img_pxls-1:0] frame_addr;
  buf_pixel_t             frame_pixel;

  assign ov7670_sioc = 1'b1;  // SCCB idle
  assign ov7670_siod = 1'bz;

  video_ctrl u_ctrl (
    .clk(clk), .rst(rst), .sw2(sw2), .frame_done(frame_done),
    .disp_mode(disp_mode), .capture_en(capture_en),
    .ov7670_rst_n(ov7670_rst_n), .ov7670_xclk(ov7670_xclk), .led(led)
  );

  ov7670_capture u_capture (
    .clk(clk), .rst(rst), .pclk(ov7670_pclk), .vsync(ov7670_vsync),
    .href(ov7670_href), .d(ov7670_d), .disp_mode(disp_mode),
    .capture_en(capture_en), .cap_wr(cap_wr), .frame_done(frame_done)
  );

  frame_buffer u_fb (
    .clk(clk), .cap_wr(cap_wr), .frame_addr(frame_addr), .frame_pixel(frame_pixel)
  );

  vga_sync u_sync (.clk(clk), .rst(rst), .scan(scan));

  vga_display u_display (
    .clk(clk), .rst(rst), .scan(scan), .disp_mode(disp_mode),
    .frame_pixel(frame_pixel), .frame_addr(frame_addr),
    .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

endmodule

`default_nettype wire

//--- tb_top_ov7670.sv
//********************
// directed tests of the camera to VGA path
// pclk runs at clk / 8, sw2 is driven as a clean level
// VGA pixels are located by counting clk from the vga_vsync fall
//********************
`default_nettype none

module tb_top_ov7670;
  localparam int img_w         = 80;
  localparam int img_h         = 60;
  localparam int line_clk      = 1600;             // 800 pixels of 2 clk
  localparam int frame_clk     = 525 * line_clk;
  localparam int vs_to_row0    = 35;               // vsync plus back porch lines
  localparam int frames_budget = 8;                // tests take about 6 frames
  localparam longint watchdog_time = longint'(frames_budget) * frame_clk * 4;

  logic       clk;
  logic       rst;
  logic       sw2;
  logic       ov7670_pclk, ov7670_vsync, ov7670_href;
  logic [7:0] ov7670_d;
  logic       ov7670_xclk, ov7670_rst_n, ov7670_sioc;
  tri1        ov7670_siod;                 // SCCB data has a pull-up on the board
  logic [7:0] led;
  logic [3:0] vga_red, vga_green, vga_blue;
  logic       vga_hsync, vga_vsync;

  logic [31:0] lfsr;
  logic [11:0] exp_img [0:img_w*img_h-1];  // expected buffer words
  logic [1:0]  cur_mode;                   // mode as the tb counts presses
  int          n_frames;                   // frames written into the buffer
  int          n_errors;
  int          n_tests;
  int          scan_cnt   = 0;             // clk since the last vga_vsync fall
  logic        scan_valid = 1'b0;
  logic        vsync_prev = 1'b1;

  top_ov7670 u_dut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // free running position tracker, sampled on the falling clk edge
  always @(negedge clk) begin
    vsync_prev <= vga_vsync;
    if (vsync_prev && !vga_vsync) begin
      scan_cnt   <= 0;
      scan_valid <= 1'b1;
    end else begin
      scan_cnt <= scan_cnt + 1;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v    = (v << 1) | int'(lfsr[31]);  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic sync_level(input logic use_v);
    return use_v ? vga_vsync : vga_hsync;
  endfunction

  task automatic report_error(input string msg);
    n_errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  task automatic step_clk(input int n);
    repeat (n) @(posedge clk);
    #1;  // inputs move just after the edge
  endtask

  task automatic pclk_cycle(input logic vs, input logic hr, input logic [7:0] b);
    ov7670_pclk  = 1'b0;  // data changes on the falling pclk edge
    ov7670_vsync = vs;
    ov7670_href  = hr;
    ov7670_d     = b;
    step_clk(4);
    ov7670_pclk  = 1'b1;
    step_clk(4);
  endtask

  // one 80 x 60 camera frame, closed by a second vsync pulse
  task automatic send_frame();
    logic [7:0] b1, b2;
    step_clk(1);
    repeat (16) pclk_cycle(1'b1, 1'b0, 8'h00);
    repeat (8) pclk_cycle(1'b0, 1'b0, 8'h00);
    for (int r = 0; r < img_h; r++) begin
      for (int c = 0; c < img_w; c++) begin
        b1 = 8'(rand_bits(8));
        b2 = 8'(rand_bits(8));
        pclk_cycle(1'b0, 1'b1, b1);
        pclk_cycle(1'b0, 1'b1, b2);
        if (cur_mode == 2'd0)  // rgb565 down to rgb444
          exp_img[r*img_w+c] = {b1[7:4], b1[2:0], b2[7], b2[4:1]};
        else if (cur_mode == 2'd1)
          exp_img[r*img_w+c] = {b2, b1[7:4]};  // y, then chroma nibble
      end
      repeat (8) pclk_cycle(1'b0, 1'b0, 8'h00);  // line blank
    end
    repeat (16) pclk_cycle(1'b1, 1'b0, 8'h00);   // end of frame
    repeat (8) pclk_cycle(1'b0, 1'b0, 8'h00);
    if (cur_mode < 2'd2)
      n_frames++;  // test modes write nothing
  endtask

  task automatic press_sw2();
    step_clk(1);
    sw2 = 1'b1;
    step_clk(6);
    sw2 = 1'b0;
    step_clk(6);
    cur_mode = cur_mode + 2'd1;
  endtask

  // led[7] frame seen, led[5:4] mode, led[3:0] frame count
  task automatic verify_led(input string what);
    logic [6:0] exp;
    exp = {n_frames > 0, cur_mode, 4'(n_frames)};
    if ({led[7], led[5:0]} !== exp)
      report_error($sformatf("%s led %h expected mode %0d frames %0d",
                             what, led, cur_mode, n_frames));
  endtask

  // colours of visible pixel (x, y), mid way through its 2 clk
  task automatic sample_pixel(input int x, input int y, output logic [11:0] rgb);
    int target;
    target = (vs_to_row0 + y) * line_clk + 2 * x;
    @(negedge clk);
    while (!(scan_valid && scan_cnt == target))
      @(negedge clk);
    rgb = {vga_red, vga_green, vga_blue};
  endtask

  task automatic check_pixel(input int x, input int y, input logic [11:0] exp,
                             input string what);
    logic [11:0] got;
    sample_pixel(x, y, got);
    if (got !== exp)
      report_error($sformatf("%s pixel (%0d,%0d) got %h expected %h", what, x, y, got, exp));
  endtask

  // low time and full period of one sync pulse, in clk
  task automatic measure_sync(input logic use_v, output int low_clk, output int per_clk);
    logic prev, cur, found;
    cur   = 1'b0;
    found = 1'b0;
    while (!found) begin
      prev  = cur;
      @(negedge clk);
      cur   = sync_level(use_v);
      found = prev && !cur;
    end
    low_clk = 0;
    while (!cur) begin
      @(negedge clk);
      cur = sync_level(use_v);
      low_clk++;
    end
    per_clk = low_clk;
    found   = 1'b0;
    while (!found) begin
      prev  = cur;
      @(negedge clk);
      cur   = sync_level(use_v);
      per_clk++;
      found = prev && !cur;
    end
  endtask

  task automatic reset_and_release();
    logic xclk_prev;
    n_tests++;
    repeat (2) @(posedge clk);
    @(negedge clk);  // still in reset
    if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1)
      report_error("syncs not high during reset");
    if ({vga_red, vga_green, vga_blue} !== 12'h000 || led !== 8'h00)
      report_error($sformatf("colours or led not 0 in reset, led %h", led));
    @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || ov7670_rst_n !== 1'b0)
      report_error("syncs or camera reset wrong just after reset");
    if ({vga_red, vga_green, vga_blue} !== 12'h000 || led !== 8'h00)
      report_error($sformatf("colours or led not 0 after reset, led %h", led));
    repeat (63) @(posedge clk);
    @(negedge clk);
    if (ov7670_rst_n !== 1'b0)
      report_error("ov7670_rst_n released before 64 clk");
    @(negedge clk);
    if (ov7670_rst_n !== 1'b1)
      report_error("ov7670_rst_n still low after 64 clk");
    xclk_prev = ov7670_xclk;
    @(negedge clk);
    if ((ov7670_xclk ^ xclk_prev) !== 1'b1)
      report_error("ov7670_xclk does not toggle every clk");
    if (ov7670_sioc !== 1'b1 || ov7670_siod !== 1'b1)
      report_error("SCCB lines not idle high");
  endtask

  task automatic sync_timing();
    int low_clk, per_clk;
    n_tests++;
    measure_sync(1'b0, low_clk, per_clk);
    if (low_clk != 192 || per_clk != line_clk)
      report_error($sformatf("hsync low %0d period %0d", low_clk, per_clk));
    measure_sync(1'b1, low_clk, per_clk);
    if (low_clk != 2 * line_clk || per_clk != frame_clk)
      report_error($sformatf("vsync low %0d period %0d", low_clk, per_clk));
  endtask

  task automatic rgb_capture();
    int x, y;
    n_tests++;
    send_frame();
    for (int i = 0; i < 16; i++) begin
      y = i * 3 + rand_bits(2) % 3;  // rising rows keep raster order
      x = rand_bits(7) % img_w;
      check_pixel(x, y, exp_img[y*img_w+x], "rgb capture");
    end
    check_pixel(img_w, 50, 12'h000, "right of window");
    check_pixel(5, img_h, 12'h000, "below window");
    verify_led("rgb capture");
  endtask

  task automatic mode_stepping();
    n_tests++;
    for (int i = 1; i <= 4; i++) begin
      press_sw2();
      if (led[5:4] !== 2'(i % 4))
        report_error($sformatf("led[5:4] %0d after press %0d", led[5:4], i));
    end
  endtask

  task automatic yuv_capture();
    int x, y;
    logic [11:0] w;
    n_tests++;
    press_sw2();
    if (led[5:4] !== 2'd1)
      report_error("mode_yuv not reached");
    send_frame();
    verify_led("yuv capture");
    for (int i = 0; i < 16; i++) begin
      y = i * 3 + rand_bits(2) % 3;
      x = rand_bits(7) % img_w;
      w = exp_img[y*img_w+x];
      check_pixel(x, y, {3{w[11:8]}}, "yuv gray");  // top nibble of y
    end
  endtask

  task automatic patterns_and_freeze();
    int x, y;
    logic [9:0] c, r;
    n_tests++;
    press_sw2();  // colour bars
    for (int i = 0; i < 8; i++) begin
      y = 100 + i * 20 + rand_bits(4);
      x = rand_bits(10) % 640;
      c = 10'(x);
      r = 10'(y);
      check_pixel(x, y, {c[6:4], c[6], r[5:2], 4'h0}, "colour bars");
    end
    press_sw2();  // gray ramp
    for (int i = 0; i < 8; i++) begin
      y = 280 + i * 24 + rand_bits(4);
      x = rand_bits(10) % 640;
      c = 10'(x);
      check_pixel(x, y, {3{c[7:4]}}, "gray ramp");
    end
    send_frame();  // buffer is frozen in this mode
    verify_led("frozen frame");
    press_sw2();   // wraps to mode_rgb
    for (int i = 0; i < 8; i++) begin
      y = 20 + i * 3 + rand_bits(1);
      x = rand_bits(7) % img_w;
      check_pixel(x, y, exp_img[y*img_w+x], "frozen buffer");
    end
  endtask

  initial begin
    rst          = 1'b1;
    sw2          = 1'b0;
    ov7670_pclk  = 1'b0;
    ov7670_vsync = 1'b0;
    ov7670_href  = 1'b0;
    ov7670_d     = 8'h00;
    lfsr         = 32'h2a8e;
    cur_mode     = 2'd0;
    n_frames     = 0;
    n_errors     = 0;
    n_tests      = 0;
    reset_and_release();
    sync_timing();
    rgb_capture();
    mode_stepping();
    yuv_capture();
    patterns_and_freeze();
    $display("tests run %0d, errors %0d", n_tests, n_errors);
    if (n_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_time);
    $display("timeout, the run did not finish within %0d video frames", frames_budget);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- ov7670_vga.f
img_pkg.sv
vga_pkg.sv
video_ctrl.sv
ov7670_capture.sv
frame_buffer.sv
vga_sync.sv
vga_display.sv
top_ov7670.sv
tb_top_ov7670.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is decided from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f ov7670_vga.f --top-module tb_top_ov7670 -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "all tests passed" sim.log; then
  exit 0
fi
exit 1
